// File: hw/atm_pager.sv
`timescale 1ns/1ps
`default_nettype none

module atm_pager #(
	parameter int win_idx = 0
) (
	input wire fclk,
	input wire rst_n,
	input wire port_wr,
	input wire [zmem_pkg::za_w-1:0] port_addr,
	input wire [7:0] port_data,
	input wire mem_req,
	input wire [zmem_pkg::za_w-1:0] mem_addr,
	input var zmem_pkg::zop_e mem_op,
	output logic [zmem_pkg::page_w-1:0] page,
	output logic romnram,
	output logic dos_on,
	output logic dos_off
);

	import zmem_pkg::*;

	logic page_wr;
	logic rom_wr;
	logic m1_hit;

	// page port also carries the window number in the top two bits
	assign page_wr = port_wr && (port_addr[7:0] == port_page_lo) &&
		(port_addr[za_w-1 -: 2] == 2'(win_idx));
	assign rom_wr = port_wr && (port_addr[7:0] == port_rom_lo);

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			page <= page_rst;
			romnram <= romnram_rst[win_idx];
		end
		else
		begin
			// pages are kept inverted
			if (page_wr)
				page <= ~port_data;
			if (rom_wr)
				romnram <= port_data[win_idx];
		end
	end

	// opcode fetch in this window
	assign m1_hit = mem_req && (mem_op == ZOP_M1) && (mem_addr[za_w-1 -: 2] == 2'(win_idx));

	assign dos_on = m1_hit && romnram && (mem_addr[za_w-1 -: 8] == dos_entry_hi);
	assign dos_off = m1_hit && !romnram;

endmodule

`default_nettype wire

// File: hw/dram_issue.sv
`timescale 1ns/1ps
`default_nettype none

module dram_issue (
	input wire fclk,
	input wire rst_n,
	input wire empty,
	input wire [zmem_pkg::zreq_w-1:0] head_data,
	input wire credit_ret,
	output logic pop,
	output logic req_valid,
	output logic [zmem_pkg::pa_w-1:0] req_addr,
	output logic req_rom,
	output logic req_rnw
);

	import zmem_pkg::*;

	logic [cred_w-1:0] cred;

	// issue only with a credit in hand
	assign pop = !empty && (cred != '0);

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			cred <= cred_w'(credits);
			req_valid <= 1'b0;
		end
		else
		begin
			req_valid <= pop;
			if (pop && !credit_ret)
				cred <= cred - 1'b1;
			else if (!pop && credit_ret && (cred != cred_w'(credits)))
				cred <= cred + 1'b1;
		end
	end

	// address above the rom and rnw bits
	always_ff @(posedge fclk)
	begin
		if (pop)
		begin
			req_addr <= head_data[zreq_w-1 -: pa_w];
			req_rom <= head_data[1];
			req_rnw <= head_data[0];
		end
	end

endmodule

`default_nettype wire

// File: hw/req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module req_fifo (
	input wire fclk,
	input wire rst_n,
	input wire push,
	input wire [zmem_pkg::zreq_w-1:0] push_data,
	input wire pop,
	output logic [zmem_pkg::zreq_w-1:0] head_data,
	output logic empty,
	output logic wait_n
);

	import zmem_pkg::*;

	logic [zreq_w-1:0] mem [fifo_depth];
	logic [fifo_ptr_w-1:0] wr_ptr;
	logic [fifo_ptr_w-1:0] rd_ptr;
	logic [fifo_cnt_w-1:0] count;
	logic do_push;
	logic do_pop;
	logic full;

	assign full = (count == fifo_cnt_w'(fifo_depth));
	assign empty = (count == '0);
	assign wait_n = !full;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// storage
	always_ff @(posedge fclk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + fifo_cnt_w'(do_push) - fifo_cnt_w'(do_pop);
		end
	end

	assign head_data = mem[rd_ptr];

endmodule

`default_nettype wire

// File: hw/zmem_map.sv
`timescale 1ns/1ps
`default_nettype none

module zmem_map (
	input wire fclk,
	input wire rst_n,
	input wire mem_req,
	input wire [zmem_pkg::za_w-1:0] mem_addr,
	input var zmem_pkg::zop_e mem_op,
	input wire [zmem_pkg::n_win-1:0][zmem_pkg::page_w-1:0] pages,
	input wire [zmem_pkg::n_win-1:0] romnram,
	input wire [zmem_pkg::n_win-1:0] dos_on,
	input wire [zmem_pkg::n_win-1:0] dos_off,
	output logic dos,
	output logic [zmem_pkg::pa_w-1:0] map_addr,
	output logic map_rom,
	output logic map_rnw
);

	import zmem_pkg::*;

	logic [1:0] win;
	logic [page_w-1:0] page_sel;
	logic [rom_pg_w-1:0] rom_pg;
	logic [win_w-1:0] offset;

	////////////////////////////////////////////////////////////
	// dos flag
	////////////////////////////////////////////////////////////
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			dos <= 1'b0;
		else if (mem_req && |dos_on)
			dos <= 1'b1;
		else if (mem_req && |dos_off)
			dos <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	// address translation
	////////////////////////////////////////////////////////////
	assign win = mem_addr[za_w-1 -: 2];
	assign offset = mem_addr[win_w-1:0];
	assign page_sel = pages[win];

	// low rom page bit is forced to 0 inside DOS
	assign rom_pg = {page_sel[4:1], dos ? 1'b0 : page_sel[0]};

	always_comb
	begin
		map_rom = romnram[win];
		if (map_rom)
			map_addr = {{(pa_w - rom_pg_w - win_w){1'b0}}, rom_pg, offset};
		else
			map_addr = {page_sel[pa_w-win_w-1:0], offset};
	end

	assign map_rnw = (mem_op != ZOP_WR);

endmodule

`default_nettype wire

// File: hw/zmem_pkg.sv
`default_nettype none

package zmem_pkg;

	////////////////////////////////////////////////////////////
	// address widths
	////////////////////////////////////////////////////////////
	localparam int za_w = 16;
	localparam int pa_w = 21;
	localparam int page_w = 8;
	localparam int win_w = 14;
	localparam int n_win = 4;
	localparam int rom_pg_w = 5;

	////////////////////////////////////////////////////////////
	// request path sizing
	////////////////////////////////////////////////////////////
	localparam int fifo_depth = 4;
	localparam int fifo_ptr_w = $clog2(fifo_depth);
	localparam int fifo_cnt_w = $clog2(fifo_depth + 1);
	localparam int credits = 2;
	localparam int cred_w = $clog2(credits + 1);

	// port decode, low address byte
	localparam logic [7:0] port_page_lo = 8'hF7;
	localparam logic [7:0] port_rom_lo = 8'h77;

	// fetch from 3Dxx in ROM enters DOS
	localparam logic [7:0] dos_entry_hi = 8'h3D;

	// reset values
	localparam logic [n_win-1:0] romnram_rst = 4'b0001;
	localparam logic [page_w-1:0] page_rst = '0;

	typedef enum logic [1:0] {
		ZOP_RD,
		ZOP_WR,
		ZOP_M1
	} zop_e;

	// physical address, rom bit, read-not-write
	localparam int zreq_w = pa_w + 2;

endpackage

`default_nettype wire

// File: hw/zmem_top.sv
`timescale 1ns/1ps
`default_nettype none

module zmem_top (
	input wire fclk,
	input wire rst_n,
	input wire port_wr,
	input wire [zmem_pkg::za_w-1:0] port_addr,
	input wire [7:0] port_data,
	input wire mem_req,
	input wire [zmem_pkg::za_w-1:0] mem_addr,
	input var zmem_pkg::zop_e mem_op,
	input wire credit_ret,
	output logic req_valid,
	output logic [zmem_pkg::pa_w-1:0] req_addr,
	output logic req_rom,
	output logic req_rnw,
	output logic wait_n,
	output logic dos
);

	import zmem_pkg::*;

	logic [n_win-1:0][page_w-1:0] pages;
	logic [n_win-1:0] romnram;
	logic [n_win-1:0] dos_on;
	logic [n_win-1:0] dos_off;
	logic [pa_w-1:0] map_addr;
	logic map_rom;
	logic map_rnw;
	logic [zreq_w-1:0] head_data;
	logic empty;
	logic pop;

	////////////////////////////////////////////////////////////
	// window pagers
	////////////////////////////////////////////////////////////
	for (genvar i = 0; i < n_win; i++)
	begin : g_pager
		atm_pager #(.win_idx(i)) i_atm_pager (
			.fclk(fclk), .rst_n(rst_n), .port_wr(port_wr), .port_addr(port_addr),
			.port_data(port_data), .mem_req(mem_req), .mem_addr(mem_addr),
			.mem_op(mem_op), .page(pages[i]), .romnram(romnram[i]),
			.dos_on(dos_on[i]), .dos_off(dos_off[i])
		);
	end

	zmem_map i_zmem_map (
		.fclk(fclk), .rst_n(rst_n), .mem_req(mem_req), .mem_addr(mem_addr),
		.mem_op(mem_op), .pages(pages), .romnram(romnram), .dos_on(dos_on),
		.dos_off(dos_off), .dos(dos), .map_addr(map_addr), .map_rom(map_rom),
		.map_rnw(map_rnw)
	);

	////////////////////////////////////////////////////////////
	// request queue and issue
	////////////////////////////////////////////////////////////
	req_fifo i_req_fifo (
		.fclk(fclk), .rst_n(rst_n), .push(mem_req), .push_data({map_addr, map_rom, map_rnw}),
		.pop(pop), .head_data(head_data), .empty(empty), .wait_n(wait_n)
	);

	dram_issue i_dram_issue (
		.fclk(fclk), .rst_n(rst_n), .empty(empty), .head_data(head_data),
		.credit_ret(credit_ret), .pop(pop), .req_valid(req_valid), .req_addr(req_addr),
		.req_rom(req_rom), .req_rnw(req_rnw)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the zmem testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f src.f --top-module tb_zmem -Mdir obj_dir -o tb_zmem
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_zmem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
	exit 0
fi
exit 1

// File: src.f
hw/zmem_pkg.sv
hw/atm_pager.sv
hw/zmem_map.sv
hw/req_fifo.sv
hw/dram_issue.sv
hw/zmem_top.sv
verif/tb_zmem.sv

// File: verif/tb_zmem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zmem;

	import zmem_pkg::*;

	localparam int max_lines = 64;
	localparam int wait_limit = 200;

	logic fclk = 1'b0;
	logic rst_n;
	logic port_wr;
	logic [za_w-1:0] port_addr;
	logic [7:0] port_data;
	logic mem_req;
	logic [za_w-1:0] mem_addr;
	zop_e mem_op;
	logic credit_ret;
	logic req_valid;
	logic [pa_w-1:0] req_addr;
	logic req_rom;
	logic req_rnw;
	logic wait_n;
	logic dos;

	logic [31:0] td [0:max_lines*6-1];
	logic [pa_w-1:0] exp_addr [0:max_lines-1];
	logic exp_rom [0:max_lines-1];
	logic exp_rnw [0:max_lines-1];
	int push_idx = 0;
	int pop_idx = 0;
	int issued_cnt = 0;
	int returned_cnt = 0;
	int cycle_cnt = 0;
	int hold_until = 0;
	int held_pulses = 0;
	int wait_low_cnt = 0;
	int held_base;
	int low_base;
	logic pause_drop;
	logic pause_open;
	int err_cnt = 0;
	int check_cnt = 0;
	logic timed_out = 1'b0;
	logic [31:0] lfsr_state = 32'h8266_3eb1;

	always #5 fclk = ~fclk;

	zmem_top i_zmem_top (
		.fclk(fclk), .rst_n(rst_n), .port_wr(port_wr), .port_addr(port_addr),
		.port_data(port_data), .mem_req(mem_req), .mem_addr(mem_addr), .mem_op(mem_op),
		.credit_ret(credit_ret), .req_valid(req_valid), .req_addr(req_addr),
		.req_rom(req_rom), .req_rnw(req_rnw), .wait_n(wait_n), .dos(dos)
	);

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_cnt++;
		if (got !== exp)
		begin
			$display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
			err_cnt++;
		end
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!wait_n && n < wait_limit)
		begin
			@(negedge fclk);
			n++;
		end
		if (!wait_n)
		begin
			$display("timeout: wait_n stayed low for %0d cycles", wait_limit);
			timed_out = 1'b1;
		end
	endtask

	task automatic drain_requests();
		int n;
		n = 0;
		while ((pop_idx != push_idx || returned_cnt != issued_cnt) && n < wait_limit)
		begin
			@(negedge fclk);
			n++;
		end
		if (pop_idx != push_idx || returned_cnt != issued_cnt)
		begin
			$display("timeout: %0d requests and %0d credits still outstanding",
				push_idx - pop_idx, issued_cnt - returned_cnt);
			timed_out = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// commands
	////////////////////////////////////////////////////////////
	task automatic write_port(input logic [za_w-1:0] addr, input logic [7:0] data);
		@(posedge fclk);
		port_wr <= 1'b1;
		port_addr <= addr;
		port_data <= data;
		@(posedge fclk);
		port_wr <= 1'b0;
		@(negedge fclk);
	endtask

	task automatic send_req(input logic [za_w-1:0] addr, input zop_e kind,
		input logic [pa_w-1:0] e_addr, input logic e_rom, input logic e_dos);
		wait_ready();
		if (timed_out)
			return;
		@(posedge fclk);
		mem_req <= 1'b1;
		mem_addr <= addr;
		mem_op <= kind;
		exp_addr[push_idx] = e_addr;
		exp_rom[push_idx] = e_rom;
		exp_rnw[push_idx] = (kind != ZOP_WR);
		push_idx++;
		@(posedge fclk);
		mem_req <= 1'b0;
		// dos settles on the push edge
		@(negedge fclk);
		check_value("dos", 32'(dos), 32'(e_dos));
	endtask

	task automatic finish_pause();
		int n;
		n = 0;
		while (cycle_cnt < hold_until && n < wait_limit)
		begin
			@(negedge fclk);
			n++;
		end
		if (cycle_cnt < hold_until)
		begin
			$display("timeout: credit pause did not end");
			timed_out = 1'b1;
		end
		else if (pause_open)
		begin
			check_value("req_valid_over_credits", 32'(held_pulses - held_base > credits), 0);
			check_value("wait_n_dropped", 32'(wait_low_cnt != low_base), 32'(pause_drop));
		end
		pause_open = 1'b0;
	endtask

	task automatic start_pause(input int cycles, input logic expect_drop);
		finish_pause();
		if (!timed_out)
			drain_requests();
		if (timed_out)
			return;
		hold_until = cycle_cnt + cycles;
		held_base = held_pulses;
		low_base = wait_low_cnt;
		pause_drop = expect_drop;
		pause_open = 1'b1;
	endtask

	initial
	begin : main_seq
		int base;
		int line;
		rst_n = 1'b0;
		port_wr = 1'b0;
		port_addr = '0;
		port_data = '0;
		mem_req = 1'b0;
		mem_addr = '0;
		mem_op = ZOP_RD;
		pause_open = 1'b0;
		for (int i = 0; i < max_lines * 6; i++)
			td[i] = '0;
		$readmemh("verif/zmem_testdata.txt", td);
		repeat (10) @(posedge fclk);
		rst_n <= 1'b1;
		@(negedge fclk);
		check_value("req_valid", 32'(req_valid), 0);
		check_value("wait_n", 32'(wait_n), 1);
		check_value("dos", 32'(dos), 0);
		line = 0;
		while (!timed_out && line < max_lines && td[line * 6] != 0)
		begin
			base = line * 6;
			case (td[base])
				1: write_port(td[base + 1][za_w-1:0], td[base + 2][7:0]);
				2: send_req(td[base + 1][za_w-1:0], zop_e'(td[base + 2][1:0]),
					td[base + 3][pa_w-1:0], td[base + 4][0], td[base + 5][0]);
				3: start_pause(int'(td[base + 1]), td[base + 2][0]);
				default:
				begin
					$display("unknown command %0h in test data line %0d", td[base], line);
					err_cnt++;
				end
			endcase
			line++;
		end
		if (!timed_out)
			finish_pause();
		if (!timed_out)
			drain_requests();
		$display("checks %0d errors %0d timeout %0d", check_cnt, err_cnt, timed_out);
		if (timed_out || err_cnt != 0)
			$display("TB FAILED");
		else
			$display("TB PASSED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// memory side
	////////////////////////////////////////////////////////////
	initial
	begin : monitor
		forever
		begin
			@(negedge fclk);
			if (rst_n && !wait_n && cycle_cnt < hold_until)
				wait_low_cnt++;
			if (rst_n && req_valid)
			begin
				issued_cnt++;
				if (cycle_cnt < hold_until)
					held_pulses++;
				if (pop_idx == push_idx)
				begin
					$display("req_valid with no request outstanding at %0t", $time);
					err_cnt++;
				end
				else
				begin
					check_value("req_addr", 32'(req_addr), 32'(exp_addr[pop_idx]));
					check_value("req_rom", 32'(req_rom), 32'(exp_rom[pop_idx]));
					check_value("req_rnw", 32'(req_rnw), 32'(exp_rnw[pop_idx]));
					pop_idx++;
				end
			end
		end
	end

	// one credit back per issued request, after a random gap
	initial
	begin : credit_gen
		int delay_left;
		delay_left = 0;
		credit_ret = 1'b0;
		forever
		begin
			@(posedge fclk);
			cycle_cnt++;
			credit_ret <= 1'b0;
			if (returned_cnt < issued_cnt && cycle_cnt >= hold_until)
			begin
				if (delay_left == 0)
				begin
					credit_ret <= 1'b1;
					returned_cnt++;
					delay_left = int'(rand_bits(3));
				end
				else
					delay_left--;
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/zmem_testdata.txt
// cmd addr data exp_addr exp_rom exp_dos, all hex
// cmd 1 port write, 2 request (data 0 rd 1 wr 2 m1), 3 pause (addr cycles, data wait_n drop)
2 0000 2 000000 1 0
1 40F7 FA 000000 0 0
1 80F7 80 000000 0 0
1 C0F7 3C 000000 0 0
1 00F7 F8 000000 0 0
2 4123 0 014123 0 0
2 BFFF 0 1FFFFF 0 0
2 C800 1 10C800 0 0
2 0010 0 01C010 1 0
1 0077 05 000000 0 0
2 8004 0 07C004 1 0
2 3C00 2 01FC00 1 0
2 3D2F 2 01FD2F 1 1
2 0010 0 018010 1 1
2 8004 0 078004 1 1
2 4100 2 014100 0 0
2 0010 0 01C010 1 0
3 0028 1 000000 0 0
2 C000 0 10C000 0 0
2 C001 1 10C001 0 0
2 4002 0 014002 0 0
2 C003 0 10C003 0 0
2 4004 1 014004 0 0
2 0005 0 01C005 1 0
2 8006 0 07C006 1 0
0 0000 0 000000 0 0
